//--- sim.f
+incdir+include
source/dsp_route_pkg.sv
source/dsp_bus_pkg.sv
source/dsp_route_regs.sv
source/dsp_source_mux.sv
source/dsp_dac_sum.sv
source/dsp_router_top.sv
test/dsp_router_model_pkg.sv
test/tb_dsp_router.sv

//--- run_sim.sh
#!/bin/sh
# build and run the router testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_dsp_router
./obj_dir/Vtb_dsp_router > "$LOG" 2>&1
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

//--- test/tb_dsp_router.sv
`timescale 1ns/1ps
`include "dsp_settings.svh"

module tb_dsp_router;

   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;
   import dsp_router_model_pkg::*;

   localparam int      PIPE_LAT = 3;   // edges from gen or select to dac
   localparam int      BUS_TMO  = 16;  // cycles before a bus wait gives up
   localparam sample_t S_MAX    = sample_t'(SAMPLE_MAX);
   localparam sample_t S_MIN    = sample_t'(SAMPLE_MIN);

   logic                    clk;
   logic                    rstn;
   sample_t                 adc_a;
   sample_t                 adc_b;
   sample_t                 gen [`DSP_N_GEN];
   sample_t                 dac_a;
   sample_t                 dac_b;
   sample_t                 scope1;
   sample_t                 scope2;
   sample_t                 pwm0;
   sample_t                 pwm1;
   logic [`DSP_ADR_W-1:0]   wb_adr;
   logic [`DSP_DAT_W-1:0]   wb_dat_w;
   logic [`DSP_DAT_W-1:0]   wb_dat_r;
   logic [`DSP_DAT_W/8-1:0] wb_sel;
   logic                    wb_we;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_ack;
   logic                    wb_err;

   integer seed;
   int     errors;

   sample_t dac_a_prev;  // expected dac a before the last gen change
   sample_t dac_b_prev;

   dsp_router_top dut (
      .clk_i    (clk),
      .rstn_i   (rstn),
      .adc_a_i  (adc_a),
      .adc_b_i  (adc_b),
      .gen_i    (gen),
      .dac_a_o  (dac_a),
      .dac_b_o  (dac_b),
      .scope1_o (scope1),
      .scope2_o (scope2),
      .pwm0_o   (pwm0),
      .pwm1_o   (pwm1),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_dat_o (wb_dat_r),
      .wb_sel_i (wb_sel),
      .wb_we_i  (wb_we),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;  // 8 ns period

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // one classic cycle with the request held until ack or err
   task automatic wb_transfer(input logic we, input slot_t slot, input offset_t offset,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic ack, output logic err);
      int waited;
      waited = 0;
      rdata  = '0;
      ack    = 1'b0;
      err    = 1'b0;
      @(posedge clk);
      wb_adr   <= {slot, offset};
      wb_dat_w <= wdata;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      @(negedge clk);
      while (!wb_ack && !wb_err && waited < BUS_TMO) begin
         @(negedge clk);
         waited++;
      end
      if (wb_ack || wb_err) begin
         rdata = wb_dat_r;  // valid in the ack cycle
         ack   = wb_ack;
         err   = wb_err;
      end else begin
         $display("bus timeout: no ack or err for address %h", {slot, offset});
         errors++;
      end
      @(posedge clk);
      wb_cyc <= 1'b0;  // idle at least one cycle
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input slot_t slot, input offset_t offset, input logic [31:0] wdata,
                           output logic ack, output logic err);
      logic [31:0] unused;
      wb_transfer(1'b1, slot, offset, wdata, unused, ack, err);
   endtask

   task automatic wb_read(input slot_t slot, input offset_t offset, output logic [31:0] rdata,
                          output logic ack, output logic err);
      wb_transfer(1'b0, slot, offset, '0, rdata, ack, err);
   endtask

   // read and compare data, ack and err against the model
   task automatic verify_read(input string tag, input slot_t slot, input offset_t offset);
      logic [31:0] rd;
      logic [31:0] exp;
      logic        ack;
      logic        err;
      logic        exp_err;
      wb_read(slot, offset, rd, ack, err);
      exp = read_value(slot, offset, exp_err);
      check_value({tag, " err"}, 32'(exp_err), 32'(err));
      check_value({tag, " ack"}, 32'(!exp_err), 32'(ack));
      if (!exp_err)
         check_value({tag, " data"}, exp, rd);
   endtask

   task automatic readback_selections(input string tag);
      for (int s = 0; s < 2 ** SLOT_W; s++) begin
         verify_read($sformatf("%s in_sel %0d", tag, s), slot_t'(s), REG_IN_SEL);
         verify_read($sformatf("%s out_sel %0d", tag, s), slot_t'(s), REG_OUT_SEL);
      end
   endtask

   task automatic route_sink(input int sink, input src_code_t code);
      logic ack;
      logic err;
      wb_write(slot_t'(sink), REG_IN_SEL, 32'(code), ack, err);
      check_value($sformatf("in_sel write %0d ack", sink), 32'(1), 32'(ack));
      m_sink_sel[sink] = code;
   endtask

   task automatic route_gen(input int g, input out_sel_t sel);
      logic ack;
      logic err;
      wb_write(slot_t'(g), REG_OUT_SEL, 32'(sel), ack, err);
      check_value($sformatf("out_sel write %0d ack", g), 32'(1), 32'(ack));
      m_out_sel[g] = sel;
   endtask

   task automatic apply_gens(input sample_t v [`DSP_N_GEN]);
      dac_a_prev = dac_value(0);  // sums of the gens being replaced
      dac_b_prev = dac_value(1);
      @(posedge clk);
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         gen[g]  <= v[g];
         m_gen[g] = v[g];
      end
   endtask

   // narrow keeps four terms inside the sample range
   task automatic drive_inputs(input logic narrow);
      sample_t v [`DSP_N_GEN];
      sample_t a;
      sample_t b;
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         v[g] = sample_t'($random(seed));
         if (narrow)
            v[g] = v[g] >>> 2;
      end
      a = sample_t'($random(seed));
      b = sample_t'($random(seed));
      apply_gens(v);
      adc_a  <= a;  // same edge as the gens
      adc_b  <= b;
      m_adc_a = a;
      m_adc_b = b;
   endtask

   // first half of the gens at one value, second half at another
   task automatic hold_extremes(input sample_t first, input sample_t second);
      sample_t v [`DSP_N_GEN];
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         v[g] = (g < `DSP_N_GEN / 2) ? first : second;
      end
      apply_gens(v);
   endtask

   // dacs keep the old sums for two edges and take the new ones on the third
   task automatic settle();
      for (int e = 1; e <= PIPE_LAT; e++) begin
         @(posedge clk);
         @(negedge clk);
         if (e < PIPE_LAT) begin
            check_value($sformatf("dac a after %0d edges", e), 32'(dac_a_prev), 32'(dac_a));
            check_value($sformatf("dac b after %0d edges", e), 32'(dac_b_prev), 32'(dac_b));
         end
      end
      dac_a_prev = dac_value(0);
      dac_b_prev = dac_value(1);
   endtask

   task automatic compare_outputs(input string tag);
      check_value({tag, " scope1"}, 32'(src_value(m_sink_sel[SINK_SCOPE1])), 32'(scope1));
      check_value({tag, " scope2"}, 32'(src_value(m_sink_sel[SINK_SCOPE2])), 32'(scope2));
      check_value({tag, " pwm0"}, 32'(src_value(m_sink_sel[SINK_PWM0])), 32'(pwm0));
      check_value({tag, " pwm1"}, 32'(src_value(m_sink_sel[SINK_PWM1])), 32'(pwm1));
      check_value({tag, " dac a"}, 32'(dac_value(0)), 32'(dac_a));
      check_value({tag, " dac b"}, 32'(dac_value(1)), 32'(dac_b));
   endtask

   initial begin
      src_code_t code;
      logic      ack;
      logic      err;
      seed       = 32'hcba1ec0f;
      errors     = 0;
      dac_a_prev = '0;
      dac_b_prev = '0;
      rstn       = 1'b0;
      adc_a      = '0;
      adc_b      = '0;
      gen        = '{default: '0};
      wb_adr     = '0;
      wb_dat_w   = '0;
      wb_sel     = '1;  // all byte lanes on
      wb_we      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      model_reset();
      repeat (8) @(posedge clk);
      rstn <= 1'b1;

      // reset defaults with sinks on the adcs and pwm off
      drive_inputs(1'b0);
      settle();
      compare_outputs("reset");
      readback_selections("reset");

      // random routing incl. unused codes
      for (int i = 0; i < 40; i++) begin
         code = src_code_t'($random(seed));
         if (i % 8 == 7)
            code = SRC_NONE;
         route_sink($unsigned($random(seed)) % `DSP_N_SINK, code);
         drive_inputs(1'b0);
         settle();
         compare_outputs($sformatf("route %0d", i));
      end

      // random dac selects with narrow and full scale gens in turn
      for (int i = 0; i < 30; i++) begin
         route_gen($unsigned($random(seed)) % `DSP_N_GEN, out_sel_t'($random(seed)));
         drive_inputs(i % 2 == 0);
         settle();
         compare_outputs($sformatf("sum %0d", i));
         verify_read($sformatf("sum %0d sat", i), slot_t'(0), REG_SAT);
      end

      // overflow both ways on both channels
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         route_gen(g, OUT_BOTH);
      end
      hold_extremes(S_MAX, S_MAX);
      settle();
      compare_outputs("sat high");
      verify_read("sat high flags", slot_t'(3), REG_SAT);
      hold_extremes(S_MIN, S_MIN);
      settle();
      compare_outputs("sat low");
      verify_read("sat low flags", slot_t'(0), REG_SAT);
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         route_gen(g, (g < `DSP_N_GEN / 2) ? OUT_A : OUT_B);
      end
      hold_extremes(S_MAX, S_MIN);
      settle();
      compare_outputs("sat split");
      verify_read("sat split flags", slot_t'(1), REG_SAT);

      // live source values including the dac feedback codes
      for (int c = 0; c < 2 ** `DSP_SEL_W; c++) begin
         verify_read($sformatf("src_val %0d", c), slot_t'(c), REG_SRC_VAL);
      end
      verify_read("undef 0xc", slot_t'(0), offset_t'('hc));
      verify_read("undef 0x14", slot_t'(2), offset_t'('h14));
      verify_read("undef 0x2", slot_t'(5), offset_t'('h2));
      wb_write(slot_t'(0), offset_t'('h20), $random(seed), ack, err);
      check_value("undef write err", 32'(1), 32'(err));
      check_value("undef write ack", 32'(0), 32'(ack));

      // past the end and read-only writes are acked and dropped
      for (int s = `DSP_N_SINK; s < 2 ** SLOT_W; s++) begin
         wb_write(slot_t'(s), REG_IN_SEL, $random(seed), ack, err);
         check_value($sformatf("in_sel slot %0d ack", s), 32'(1), 32'(ack));
      end
      for (int s = `DSP_N_GEN; s < 2 ** SLOT_W; s++) begin
         wb_write(slot_t'(s), REG_OUT_SEL, $random(seed), ack, err);
         check_value($sformatf("out_sel slot %0d ack", s), 32'(1), 32'(ack));
      end
      wb_write(slot_t'(0), REG_SAT, '1, ack, err);
      check_value("sat write ack", 32'(1), 32'(ack));
      wb_write(slot_t'(6), REG_SRC_VAL, '1, ack, err);
      check_value("src_val write ack", 32'(1), 32'(ack));
      settle();
      compare_outputs("ignored writes");
      readback_selections("ignored writes");

      $display("router test done, %0d errors", errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- test/dsp_router_model_pkg.sv
`include "dsp_settings.svh"

package dsp_router_model_pkg;

   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;

   localparam int SAMPLE_MAX = 2 ** (`DSP_SAMPLE_W - 1) - 1;
   localparam int SAMPLE_MIN = -(2 ** (`DSP_SAMPLE_W - 1));

   // mirror of routing config and analog inputs
   src_code_t m_sink_sel [`DSP_N_SINK];
   out_sel_t  m_out_sel  [`DSP_N_GEN];
   sample_t   m_gen      [`DSP_N_GEN];
   sample_t   m_adc_a;
   sample_t   m_adc_b;

   function automatic void model_reset();
      m_sink_sel = '{SRC_ADC_A, SRC_ADC_B, SRC_NONE, SRC_NONE}; // scope1, scope2, pwm0, pwm1
      m_out_sel  = '{default: OUT_OFF};
      m_gen      = '{default: '0};
      m_adc_a    = '0;
      m_adc_b    = '0;
   endfunction

   // full precision sum of the gens routed to channel ch, 0 is dac a
   function automatic int raw_sum(input int ch);
      int acc;
      acc = 0;
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         if ((m_out_sel[g] & (ch == 0 ? OUT_A : OUT_B)) != OUT_OFF)
            acc += int'(m_gen[g]);  // signed sample
      end
      return acc;
   endfunction

   function automatic sample_t dac_value(input int ch);
      int acc;
      acc = raw_sum(ch);
      if (acc > SAMPLE_MAX)
         acc = SAMPLE_MAX;
      else if (acc < SAMPLE_MIN)
         acc = SAMPLE_MIN;
      return sample_t'(acc);
   endfunction

   function automatic logic sat_flag(input int ch);
      return raw_sum(ch) > SAMPLE_MAX || raw_sum(ch) < SAMPLE_MIN;
   endfunction

   // gens at 0..3, then adcs, then dac feedback
   function automatic sample_t src_value(input src_code_t code);
      sample_t v;
      v = '0;  // unused codes and SRC_NONE
      if (int'(code) < `DSP_N_GEN)
         v = m_gen[int'(code)];
      else if (code == SRC_ADC_A)
         v = m_adc_a;
      else if (code == SRC_ADC_B)
         v = m_adc_b;
      else if (code == SRC_DAC_A)
         v = dac_value(0);
      else if (code == SRC_DAC_B)
         v = dac_value(1);
      return v;
   endfunction

   // expected read word, err for unmapped offsets
   function automatic logic [`DSP_DAT_W-1:0] read_value(input slot_t slot,
                                                        input offset_t offset,
                                                        output logic err);
      logic [`DSP_DAT_W-1:0] rd;
      rd  = '0;
      err = 1'b0;
      if (offset == REG_IN_SEL && int'(slot) < `DSP_N_SINK)
         rd[`DSP_SEL_W-1:0] = m_sink_sel[int'(slot)];
      else if (offset == REG_OUT_SEL && int'(slot) < `DSP_N_GEN)
         rd[1:0] = m_out_sel[int'(slot)];
      else if (offset == REG_SAT)
         rd[1:0] = {sat_flag(1), sat_flag(0)};
      else if (offset == REG_SRC_VAL)
         rd[`DSP_SAMPLE_W-1:0] = src_value(src_code_t'(slot));  // zero extended
      else if (offset != REG_IN_SEL && offset != REG_OUT_SEL)
         err = 1'b1;  // slots past the end read 0 without err
      return rd;
   endfunction

endpackage

//--- source/dsp_router_top.sv
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_router_top (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   // analog side
   input  dsp_route_pkg::sample_t   adc_a_i,
   input  dsp_route_pkg::sample_t   adc_b_i,
   input  dsp_route_pkg::sample_t   gen_i [`DSP_N_GEN],
   output dsp_route_pkg::sample_t   dac_a_o,
   output dsp_route_pkg::sample_t   dac_b_o,
   // sinks
   output dsp_route_pkg::sample_t   scope1_o,
   output dsp_route_pkg::sample_t   scope2_o,
   output dsp_route_pkg::sample_t   pwm0_o,
   output dsp_route_pkg::sample_t   pwm1_o,
   // wishbone classic
   input  logic [`DSP_ADR_W-1:0]    wb_adr_i,
   input  logic [`DSP_DAT_W-1:0]    wb_dat_i,
   output logic [`DSP_DAT_W-1:0]    wb_dat_o,
   input  logic [`DSP_DAT_W/8-1:0]  wb_sel_i,
   input  logic                     wb_we_i,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   output logic                     wb_ack_o,
   output logic                     wb_err_o
);

   import dsp_route_pkg::*;

   src_code_t  sink_sel [`DSP_N_SINK];  // regs -> mux
   src_code_t  src_query;               // bus slot as source code
   sample_t    src_val;                 // mux -> regs readback
   out_sel_t   out_sel  [`DSP_N_GEN];   // regs -> summer
   logic [1:0] sat;                     // summer -> regs
   sample_t    sinks    [`DSP_N_SINK];

   // register block steers mux and summer
   dsp_route_regs u_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_ack_o    (wb_ack_o),
      .wb_err_o    (wb_err_o),
      .src_val_i   (src_val),
      .sat_i       (sat),
      .sink_sel_o  (sink_sel),
      .src_query_o (src_query),
      .out_sel_o   (out_sel)
   );

   dsp_source_mux u_mux (
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .gen_i       (gen_i),
      .dac_a_i     (dac_a_o),  // dac outputs loop back as sources
      .dac_b_i     (dac_b_o),
      .sink_sel_i  (sink_sel),
      .src_query_i (src_query),
      .sinks_o     (sinks),
      .src_val_o   (src_val)
   );

   dsp_dac_sum u_sum (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .gen_i     (gen_i),
      .out_sel_i (out_sel),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .sat_o     (sat)
   );

   assign scope1_o = sinks[SINK_SCOPE1];
   assign scope2_o = sinks[SINK_SCOPE2];
   assign pwm0_o   = sinks[SINK_PWM0];
   assign pwm1_o   = sinks[SINK_PWM1];

endmodule

//--- source/dsp_dac_sum.sv
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_dac_sum (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  dsp_route_pkg::sample_t   gen_i     [`DSP_N_GEN],
   input  dsp_route_pkg::out_sel_t  out_sel_i [`DSP_N_GEN],
   output dsp_route_pkg::sample_t   dac_a_o,
   output dsp_route_pkg::sample_t   dac_b_o,
   output logic [1:0]               sat_o     // {dac b, dac a} clamped
);

   import dsp_route_pkg::*;

   localparam int N_CH   = 2;               // dac a, dac b
   localparam int N_PAIR = `DSP_N_GEN / 2;

   typedef logic signed [`DSP_SUM_W-1:0] sum_t;

   // clamp limits of a 14 bit signed sample
   localparam sum_t SAT_MAX = sum_t'(2 ** (`DSP_SAMPLE_W - 1) - 1);
   localparam sum_t SAT_MIN = sum_t'(-(2 ** (`DSP_SAMPLE_W - 1)));

   // select bit per channel
   localparam out_sel_t CH_MASK [N_CH] = '{OUT_A, OUT_B};

   sum_t            masked  [N_CH][`DSP_N_GEN];
   sum_t            pair_q  [N_CH][N_PAIR];    // stage 1
   sum_t            total_d [N_CH];
   sum_t            total_q [N_CH];            // stage 2
   sample_t         clamp_d [N_CH];
   logic [N_CH-1:0] sat_d;
   sample_t         dac_q   [N_CH];            // stage 3
   logic [N_CH-1:0] sat_q;

   // sign extend, zero when gen not routed to this channel
   always_comb begin
      for (int ch = 0; ch < N_CH; ch++) begin
         for (int g = 0; g < `DSP_N_GEN; g++) begin
            masked[ch][g] = |(out_sel_i[g] & CH_MASK[ch]) ? sum_t'(gen_i[g]) : '0;
         end
      end
   end

   // channel total from the pair sums
   always_comb begin
      for (int ch = 0; ch < N_CH; ch++) begin
         total_d[ch] = '0;
         for (int p = 0; p < N_PAIR; p++) begin
            total_d[ch] = total_d[ch] + pair_q[ch][p];
         end
      end
   end

   // saturate to sample range
   always_comb begin
      for (int ch = 0; ch < N_CH; ch++) begin
         if (total_q[ch] > SAT_MAX) begin
            clamp_d[ch] = sample_t'(SAT_MAX);
            sat_d[ch]   = 1'b1;
         end else if (total_q[ch] < SAT_MIN) begin
            clamp_d[ch] = sample_t'(SAT_MIN);
            sat_d[ch]   = 1'b1;
         end else begin
            clamp_d[ch] = sample_t'(total_q[ch]);  // fits, drop guard bits
            sat_d[ch]   = 1'b0;
         end
      end
   end

   // 3 stage pipe, pair -> total -> clamped
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int ch = 0; ch < N_CH; ch++) begin
            for (int p = 0; p < N_PAIR; p++) begin
               pair_q[ch][p] <= '0;
            end
            total_q[ch] <= '0;
            dac_q[ch]   <= '0;
         end
         sat_q <= '0;
      end else begin
         for (int ch = 0; ch < N_CH; ch++) begin
            for (int p = 0; p < N_PAIR; p++) begin
               pair_q[ch][p] <= masked[ch][2*p] + masked[ch][2*p+1];
            end
            total_q[ch] <= total_d[ch];
            dac_q[ch]   <= clamp_d[ch];
         end
         sat_q <= sat_d;  // flag stays aligned with its sample
      end
   end

   assign dac_a_o = dac_q[0];
   assign dac_b_o = dac_q[1];
   assign sat_o   = sat_q;

endmodule

//--- source/dsp_source_mux.sv
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_source_mux (
   input  dsp_route_pkg::sample_t   adc_a_i,
   input  dsp_route_pkg::sample_t   adc_b_i,
   input  dsp_route_pkg::sample_t   gen_i      [`DSP_N_GEN],
   input  dsp_route_pkg::sample_t   dac_a_i,   // dac feedback
   input  dsp_route_pkg::sample_t   dac_b_i,
   input  dsp_route_pkg::src_code_t sink_sel_i [`DSP_N_SINK],
   input  dsp_route_pkg::src_code_t src_query_i,
   output dsp_route_pkg::sample_t   sinks_o    [`DSP_N_SINK],
   output dsp_route_pkg::sample_t   src_val_o  // for bus readback
);

   import dsp_route_pkg::*;

   localparam int N_CODES = 2 ** `DSP_SEL_W;

   sample_t src_tbl [N_CODES];  // value per source code

   // source table, everything not listed reads zero (incl. SRC_NONE)
   always_comb begin
      for (int c = 0; c < N_CODES; c++) begin
         src_tbl[c] = '0;
      end
      for (int g = 0; g < `DSP_N_GEN; g++) begin
         src_tbl[SRC_GEN0 + g] = gen_i[g];
      end
      src_tbl[SRC_ADC_A] = adc_a_i;
      src_tbl[SRC_ADC_B] = adc_b_i;
      src_tbl[SRC_DAC_A] = dac_a_i;
      src_tbl[SRC_DAC_B] = dac_b_i;
   end

   // one lookup per sink, purely combinational
   always_comb begin
      for (int s = 0; s < `DSP_N_SINK; s++) begin
         sinks_o[s] = src_tbl[sink_sel_i[s]];
      end
   end

   assign src_val_o = src_tbl[src_query_i];  // extra port for REG_SRC_VAL

endmodule

//--- source/dsp_route_regs.sv
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_route_regs (
   input  logic                       clk_i,
   input  logic                       rstn_i,
   // wishbone classic slave
   input  logic [`DSP_ADR_W-1:0]      wb_adr_i,
   input  logic [`DSP_DAT_W-1:0]      wb_dat_i,
   output logic [`DSP_DAT_W-1:0]      wb_dat_o,
   input  logic [`DSP_DAT_W/8-1:0]    wb_sel_i,  // byte lanes ignored, full-word regs
   input  logic                       wb_we_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   // routing side
   input  dsp_route_pkg::sample_t     src_val_i,  // value of src_query_o
   input  logic [1:0]                 sat_i,      // {dac b, dac a} overflow
   output dsp_route_pkg::src_code_t   sink_sel_o [`DSP_N_SINK],
   output dsp_route_pkg::src_code_t   src_query_o,
   output dsp_route_pkg::out_sel_t    out_sel_o  [`DSP_N_GEN]
);

   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;

   localparam int SINK_IW = $clog2(`DSP_N_SINK);
   localparam int GEN_IW  = $clog2(`DSP_N_GEN);

   slot_t                 slot;
   offset_t               offset;
   logic                  in_sink;  // slot addresses an existing sink
   logic                  in_gen;   // slot addresses an existing generator
   logic                  req_new;  // request not yet answered
   logic                  hit;      // offset is mapped
   logic [`DSP_DAT_W-1:0] rd_data;

   assign slot   = wb_adr_i[`DSP_ADR_W-1 -: SLOT_W];
   assign offset = wb_adr_i[OFFSET_W-1:0];

   assign in_sink = slot < slot_t'(`DSP_N_SINK);
   assign in_gen  = slot < slot_t'(`DSP_N_GEN);

   // master holds stb through the ack cycle, so skip that one
   assign req_new = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

   // slot doubles as source code for live readback
   assign src_query_o = src_code_t'(slot);

   // read mux, zero-extended fields
   always_comb begin
      hit     = 1'b1;
      rd_data = '0;
      case (offset)
         REG_IN_SEL: begin
            if (in_sink)
               rd_data[`DSP_SEL_W-1:0] = sink_sel_o[slot[SINK_IW-1:0]];
         end
         REG_OUT_SEL: begin
            if (in_gen)
               rd_data[OUT_SEL_W-1:0] = out_sel_o[slot[GEN_IW-1:0]];
         end
         REG_SAT: begin
            rd_data[1:0] = sat_i;  // same for every slot
         end
         REG_SRC_VAL: begin
            rd_data[`DSP_SAMPLE_W-1:0] = src_val_i;  // raw bits, no sign extension
         end
         default: begin
            hit = 1'b0;  // unmapped -> err
         end
      endcase
   end

   // single-cycle ack or err, one edge after the request
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
      end else begin
         wb_ack_o <= req_new & hit;
         wb_err_o <= req_new & ~hit;
      end
   end

   // read data lines up with ack/err
   always_ff @(posedge clk_i) begin
      if (req_new)
         wb_dat_o <= rd_data;
   end

   // selection registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sink_sel_o[SINK_SCOPE1] <= SRC_ADC_A;
         sink_sel_o[SINK_SCOPE2] <= SRC_ADC_B;
         sink_sel_o[SINK_PWM0]   <= SRC_NONE;  // pwm off until configured
         sink_sel_o[SINK_PWM1]   <= SRC_NONE;
         for (int g = 0; g < `DSP_N_GEN; g++) begin
            out_sel_o[g] <= OUT_OFF;
         end
      end else if (req_new && wb_we_i) begin
         // out of range slots are acked, write dropped
         if (offset == REG_IN_SEL && in_sink)
            sink_sel_o[slot[SINK_IW-1:0]] <= wb_dat_i[`DSP_SEL_W-1:0];
         if (offset == REG_OUT_SEL && in_gen)
            out_sel_o[slot[GEN_IW-1:0]] <= wb_dat_i[OUT_SEL_W-1:0];
         // sat and src_val are ro, writes fall through
      end
   end

endmodule

//--- source/dsp_bus_pkg.sv
`include "dsp_settings.svh"

package dsp_bus_pkg;

   // address = {slot, offset}
   localparam int SLOT_W   = 4;
   localparam int OFFSET_W = `DSP_ADR_W - SLOT_W; // low 16 bits

   typedef logic [SLOT_W-1:0]   slot_t;   // adr bits 19..16
   typedef logic [OFFSET_W-1:0] offset_t; // adr bits 15..0

   // register offsets inside a slot
   localparam offset_t REG_IN_SEL  = offset_t'('h0);  // source code of sink[slot]
   localparam offset_t REG_OUT_SEL = offset_t'('h4);  // dac select of gen[slot]
   localparam offset_t REG_SAT     = offset_t'('h8);  // overflow flags, ro
   localparam offset_t REG_SRC_VAL = offset_t'('h10); // live value of source[slot], ro

endpackage

//--- source/dsp_route_pkg.sv
`include "dsp_settings.svh"

package dsp_route_pkg;

   typedef logic signed [`DSP_SAMPLE_W-1:0] sample_t; // one adc/dac sample
   typedef logic [`DSP_SEL_W-1:0]           src_code_t;

   localparam int OUT_SEL_W = 2; // bit 0 dac a, bit 1 dac b
   typedef logic [OUT_SEL_W-1:0] out_sel_t;

   // source codes
   localparam src_code_t SRC_GEN0  = src_code_t'(0); // gens 0..3 at codes 0..3
   localparam src_code_t SRC_ADC_A = src_code_t'(4);
   localparam src_code_t SRC_ADC_B = src_code_t'(5);
   localparam src_code_t SRC_DAC_A = src_code_t'(6); // dac outputs fed back
   localparam src_code_t SRC_DAC_B = src_code_t'(7);
   // codes 8..14 unused, read as zero
   localparam src_code_t SRC_NONE  = src_code_t'(15);

   // output select encodings
   localparam out_sel_t OUT_OFF  = 2'b00;
   localparam out_sel_t OUT_A    = 2'b01;
   localparam out_sel_t OUT_B    = 2'b10;
   localparam out_sel_t OUT_BOTH = 2'b11;

   // sink indices
   localparam int SINK_SCOPE1 = 0;
   localparam int SINK_SCOPE2 = 1;
   localparam int SINK_PWM0   = 2;
   localparam int SINK_PWM1   = 3;

endpackage

//--- include/dsp_settings.svh
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// sample width of adc, dac and generators
`define DSP_SAMPLE_W 14

// source code width, 16 codes
`define DSP_SEL_W 4

// generator inputs feeding the dac summers
`define DSP_N_GEN 4

// sinks: scope 1, scope 2, pwm 0, pwm 1
`define DSP_N_SINK 4

// wishbone address and data widths
`define DSP_ADR_W 20
`define DSP_DAT_W 32

// two guard bits, enough for four full scale terms
`define DSP_SUM_W (`DSP_SAMPLE_W + 2)

`endif
